/* Bender.yml */
package:
  name: udp_echo

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/udp_hdr_pkg.sv
      - hdl/udp_echo_pkg.sv
      - hdl/udp_port_filter.sv
      - hdl/udp_reply_header.sv
      - hdl/udp_payload_fifo.sv
      - hdl/udp_first_byte_latch.sv
      - hdl/udp_echo_top.sv
  - target: simulation
    files:
      - bench/udp_echo_checker.sv
      - bench/udp_echo_tb.sv

/* bench/udp_echo_checker.sv */
// ==============================
// UDP echo checker
// Predicts replies from rx traffic
// and compares the tx handshakes
// ==============================
`timescale 1ns/10ps

module udp_echo_checker (
    input  logic                   clk_125mhz,
    input  logic                   rst_125mhz,
    input  logic                   rx_hdr_valid, rx_hdr_ready,
    input  udp_hdr_pkg::ip_addr_t  rx_ip_source_ip,
    input  udp_hdr_pkg::udp_port_t rx_source_port, rx_dest_port,
    input  udp_hdr_pkg::udp_len_t  rx_length,
    input  logic                   rx_payload_valid, rx_payload_ready,
    input  logic                   rx_payload_last, rx_payload_user,
    input  udp_hdr_pkg::byte_t     rx_payload_data,
    input  logic                   tx_hdr_valid, tx_hdr_ready,
    input  udp_hdr_pkg::ip_addr_t  tx_ip_source_ip, tx_ip_dest_ip,
    input  udp_hdr_pkg::ip_ttl_t   tx_ip_ttl,
    input  udp_hdr_pkg::ip_dscp_t  tx_ip_dscp,
    input  udp_hdr_pkg::ip_ecn_t   tx_ip_ecn,
    input  udp_hdr_pkg::udp_port_t tx_source_port, tx_dest_port,
    input  udp_hdr_pkg::udp_len_t  tx_length,
    input  udp_hdr_pkg::udp_csum_t tx_checksum,
    input  logic                   tx_payload_valid, tx_payload_ready,
    input  logic                   tx_payload_last, tx_payload_user,
    input  udp_hdr_pkg::byte_t     tx_payload_data, led,
    output int                     error_count, echoed_count,
    output int                     dropped_count, pending_count
);
    import udp_hdr_pkg::*;

    localparam logic [15:0] ECHO_PORT = 16'd1234;
    localparam logic [31:0] LOCAL_IP  = 32'hc0a8_0180;
    localparam logic [7:0]  REPLY_TTL = 8'd64;

    // Header entry is {dest ip, source port, dest port, length}
    logic [79:0] hdr_q [$];
    // Byte entry is {user, last, data}
    logic [9:0]  byte_q [$];
    logic        rx_echo = 1'b0;
    udp_port_t   rx_port;
    logic        tx_first = 1'b1;
    byte_t       first_byte;
    logic        led_check = 1'b0;
    logic        reset_checked = 1'b0;
    int          frame_bytes = 0;

    initial begin
        error_count   = 0;
        echoed_count  = 0;
        dropped_count = 0;
        pending_count = 0;
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected 0x%0h, got 0x%0h", name, expected, actual);
            error_count++;
        end
    endtask

    // Mid-cycle sampling, inputs change just after the rising edge
    always @(negedge clk_125mhz) begin
        logic [79:0] exp_hdr;
        logic [9:0]  exp_byte;
        if (!rst_125mhz) begin
            if (!reset_checked) begin
                reset_checked = 1'b1;
                compare_value("tx_hdr_valid", 0, tx_hdr_valid);
                compare_value("tx_payload_valid", 0, tx_payload_valid);
                compare_value("led", 0, led);
                compare_value("rx_hdr_ready", 1, rx_hdr_ready);
            end
            if (led_check) begin
                led_check = 1'b0;
                compare_value("led", first_byte, led);
            end
            if (rx_hdr_valid && rx_hdr_ready) begin
                rx_echo = (rx_dest_port == ECHO_PORT);
                rx_port = rx_dest_port;
                if (rx_echo) begin
                    hdr_q.push_back({rx_ip_source_ip, rx_dest_port, rx_source_port, rx_length});
                end
            end
            if (rx_payload_valid && rx_payload_ready) begin
                if (rx_echo) begin
                    byte_q.push_back({rx_payload_user, rx_payload_last, rx_payload_data});
                end else if (rx_payload_last) begin
                    dropped_count++;
                    $display("Frame to port %0d dropped", rx_port);
                end
            end
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (hdr_q.size() == 0) begin
                    $display("Reply header sent while no echoed frame was pending");
                    error_count++;
                end else begin
                    exp_hdr = hdr_q.pop_front();
                    compare_value("tx_ip_dest_ip", exp_hdr[79:48], tx_ip_dest_ip);
                    compare_value("tx_source_port", exp_hdr[47:32], tx_source_port);
                    compare_value("tx_dest_port", exp_hdr[31:16], tx_dest_port);
                    compare_value("tx_length", exp_hdr[15:0], tx_length);
                    compare_value("tx_ip_source_ip", LOCAL_IP, tx_ip_source_ip);
                    compare_value("tx_ip_ttl", REPLY_TTL, tx_ip_ttl);
                    compare_value("tx_ip_dscp", 0, tx_ip_dscp);
                    compare_value("tx_ip_ecn", 0, tx_ip_ecn);
                    compare_value("tx_checksum", 0, tx_checksum);
                end
            end
            if (tx_payload_valid && tx_payload_ready) begin
                if (byte_q.size() == 0) begin
                    $display("Payload byte sent while no echoed byte was pending");
                    error_count++;
                end else begin
                    exp_byte = byte_q.pop_front();
                    if (tx_first) first_byte = exp_byte[7:0];
                    compare_value("tx_payload_data", exp_byte[7:0], tx_payload_data);
                    compare_value("tx_payload_last", exp_byte[8], tx_payload_last);
                    compare_value("tx_payload_user", exp_byte[9], tx_payload_user);
                    tx_first = exp_byte[8];
                    frame_bytes++;
                    if (exp_byte[8]) begin
                        echoed_count++;
                        led_check = 1'b1;
                        $display("Frame %0d echoed, %0d bytes, errors so far %0d",
                                 echoed_count, frame_bytes, error_count);
                        frame_bytes = 0;
                    end
                end
            end
            pending_count = hdr_q.size() + byte_q.size() + int'(led_check);
        end
    end

endmodule

/* bench/udp_echo_tb.sv */
// ==============================
// UDP echo testbench
// Sends a table of frames through
// the echo core, tx ready throttled
// ==============================
`timescale 1ns/10ps

module udp_echo_tb;
    import udp_hdr_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int N_FRAMES   = 6;

    typedef struct packed {
        udp_port_t  dest_port;
        udp_port_t  source_port;
        ip_addr_t   source_ip;
        udp_len_t   length;
        logic [7:0] byte_count;
        logic       user;
        logic       throttle;
    } frame_t;

    // dest port, source port, source IP, length, bytes, tuser, throttle
    frame_t frames [N_FRAMES] = '{
        '{16'd1234, 16'd5000,  32'hc0a8_0105, 16'd12, 8'd4,  1'b0, 1'b0},
        '{16'd80,   16'd4000,  32'hc0a8_0106, 16'd28, 8'd20, 1'b0, 1'b0},
        '{16'd1234, 16'd6001,  32'h0a00_0001, 16'd9,  8'd1,  1'b1, 1'b0},
        '{16'd1234, 16'd7777,  32'hc0a8_01fe, 16'd48, 8'd40, 1'b0, 1'b1},
        '{16'd53,   16'd1234,  32'hc0a8_0107, 16'd16, 8'd8,  1'b1, 1'b1},
        '{16'd1234, 16'd65535, 32'hffff_ffff, 16'd40, 8'd32, 1'b1, 1'b1}
    };

    logic      clk_125mhz, rst_125mhz;
    logic      rx_hdr_valid, rx_hdr_ready, rx_payload_valid, rx_payload_ready;
    logic      rx_payload_last, rx_payload_user;
    ip_addr_t  rx_ip_source_ip, tx_ip_source_ip, tx_ip_dest_ip;
    udp_port_t rx_source_port, rx_dest_port, tx_source_port, tx_dest_port;
    udp_len_t  rx_length, tx_length;
    byte_t     rx_payload_data, tx_payload_data, led;
    logic      tx_hdr_valid, tx_hdr_ready, tx_payload_valid, tx_payload_ready;
    logic      tx_payload_last, tx_payload_user;
    ip_ttl_t   tx_ip_ttl;
    ip_dscp_t  tx_ip_dscp;
    ip_ecn_t   tx_ip_ecn;
    udp_csum_t tx_checksum;
    int        error_count, echoed_count, dropped_count, pending_count;

    logic [31:0] lfsr_state = 32'h2b50_d001;
    logic        throttle_on = 1'b0;
    byte_t       payload [N_FRAMES][40];

    udp_echo_top i_udp_echo_top (.*);

    udp_echo_checker i_udp_echo_checker (.*);

    // Galois LFSR, one step per bit taken
    function automatic logic [7:0] random_bits(input int count);
        logic [7:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
            value = {value[6:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic send_frame(input int f);
        rx_hdr_valid    = 1'b1;
        rx_dest_port    = frames[f].dest_port;
        rx_source_port  = frames[f].source_port;
        rx_ip_source_ip = frames[f].source_ip;
        rx_length       = frames[f].length;
        do @(negedge clk_125mhz); while (!rx_hdr_ready);
        throttle_on = frames[f].throttle;
        @(posedge clk_125mhz);
        #1;
        rx_hdr_valid = 1'b0;
        for (int b = 0; b < frames[f].byte_count; b++) begin
            rx_payload_valid = 1'b1;
            rx_payload_data  = payload[f][b];
            rx_payload_last  = (b == frames[f].byte_count - 1);
            rx_payload_user  = rx_payload_last && frames[f].user;
            do @(negedge clk_125mhz); while (!rx_payload_ready);
            @(posedge clk_125mhz);
            #1;
        end
        rx_payload_valid = 1'b0;
        rx_payload_last  = 1'b0;
        rx_payload_user  = 1'b0;
    endtask

    initial begin
        clk_125mhz = 1'b0;
        forever #(CLK_PERIOD / 2) clk_125mhz = ~clk_125mhz;
    end

    // Random tx ready while a throttled frame is running
    always @(posedge clk_125mhz) begin
        logic [7:0] bits;
        #1;
        bits = throttle_on ? random_bits(2) : 8'h03;
        tx_hdr_ready     = bits[1];
        tx_payload_ready = bits[0];
    end

    initial begin
        longint budget;
        budget = 0;
        for (int i = 0; i < N_FRAMES; i++) begin
            budget += frames[i].byte_count + 20;
        end
        #(4 * budget * CLK_PERIOD);
        $display("Timeout: echoed frames did not all reach the tx ports in time");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        rst_125mhz       = 1'b1;
        rx_hdr_valid     = 1'b0;
        rx_ip_source_ip  = '0;
        rx_source_port   = '0;
        rx_dest_port     = '0;
        rx_length        = '0;
        rx_payload_data  = '0;
        rx_payload_valid = 1'b0;
        rx_payload_last  = 1'b0;
        rx_payload_user  = 1'b0;
        tx_hdr_ready     = 1'b1;
        tx_payload_ready = 1'b1;
        for (int f = 0; f < N_FRAMES; f++) begin
            for (int b = 0; b < frames[f].byte_count; b++) begin
                payload[f][b] = random_bits(8);
            end
        end
        repeat (16) @(posedge clk_125mhz);
        #1;
        rst_125mhz = 1'b0;
        for (int f = 0; f < N_FRAMES; f++) begin
            send_frame(f);
        end
        wait (pending_count == 0);
        $display("Frames echoed %0d, dropped %0d, errors %0d",
                 echoed_count, dropped_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+hdl
hdl/udp_hdr_pkg.sv
hdl/udp_echo_pkg.sv
hdl/udp_port_filter.sv
hdl/udp_reply_header.sv
hdl/udp_payload_fifo.sv
hdl/udp_first_byte_latch.sv
hdl/udp_echo_top.sv
bench/udp_echo_checker.sv
bench/udp_echo_tb.sv

/* hdl/udp_echo_defines.svh */
// ==============================
// UDP echo constants
// Echo port, reply TTL, local
// IPv4 address and payload FIFO
// sizing for the echo core
// ==============================

`ifndef UDP_ECHO_DEFINES_SVH
`define UDP_ECHO_DEFINES_SVH

// Only frames to this port get a reply
`define UDP_ECHO_PORT 16'd1234

`define UDP_ECHO_TTL 8'd64

// 192.168.1.128
`define UDP_LOCAL_IP {8'd192, 8'd168, 8'd1, 8'd128}

// Payload FIFO entries, power of two
`define UDP_FIFO_DEPTH 256
`define UDP_FIFO_ADDR_W 8

`endif

/* hdl/udp_echo_pkg.sv */
// ==============================
// UDP echo control types
// State encoding of the echo
// port filter
// ==============================

package udp_echo_pkg;

    // Per-frame decision, held until the last payload byte
    typedef enum logic [1:0] {
        st_idle,
        st_echo,
        st_drop
    } filter_state_e;

endpackage

/* hdl/udp_echo_top.sv */
// ==============================
// UDP echo core
// Replies to UDP frames on the
// echo port with the same payload
// ==============================
`timescale 1ns/10ps
`include "udp_echo_defines.svh"

module udp_echo_top (
    input  logic                   clk_125mhz,
    input  logic                   rst_125mhz,
    input  logic                   rx_hdr_valid,
    output logic                   rx_hdr_ready,
    input  udp_hdr_pkg::ip_addr_t  rx_ip_source_ip,
    input  udp_hdr_pkg::udp_port_t rx_source_port,
    input  udp_hdr_pkg::udp_port_t rx_dest_port,
    input  udp_hdr_pkg::udp_len_t  rx_length,
    input  udp_hdr_pkg::byte_t     rx_payload_data,
    input  logic                   rx_payload_valid,
    output logic                   rx_payload_ready,
    input  logic                   rx_payload_last,
    input  logic                   rx_payload_user,
    output logic                   tx_hdr_valid,
    input  logic                   tx_hdr_ready,
    output udp_hdr_pkg::ip_addr_t  tx_ip_source_ip,
    output udp_hdr_pkg::ip_addr_t  tx_ip_dest_ip,
    output udp_hdr_pkg::ip_ttl_t   tx_ip_ttl,
    output udp_hdr_pkg::ip_dscp_t  tx_ip_dscp,
    output udp_hdr_pkg::ip_ecn_t   tx_ip_ecn,
    output udp_hdr_pkg::udp_port_t tx_source_port,
    output udp_hdr_pkg::udp_port_t tx_dest_port,
    output udp_hdr_pkg::udp_len_t  tx_length,
    output udp_hdr_pkg::udp_csum_t tx_checksum,
    output udp_hdr_pkg::byte_t     tx_payload_data,
    output logic                   tx_payload_valid,
    input  logic                   tx_payload_ready,
    output logic                   tx_payload_last,
    output logic                   tx_payload_user,
    output udp_hdr_pkg::byte_t     led
);
    import udp_hdr_pkg::*;

    // Filter to header stage
    logic  hdr_load;
    logic  hdr_free;

    // Filter to FIFO write port
    logic  wr_valid;
    logic  wr_ready;
    byte_t wr_data;
    logic  wr_last;
    logic  wr_user;

    udp_port_filter i_udp_port_filter (.*);

    udp_reply_header i_udp_reply_header (.*);

    udp_payload_fifo #(
        .DEPTH(1 << `UDP_FIFO_ADDR_W)
    ) i_udp_payload_fifo (.*);

    udp_first_byte_latch i_udp_first_byte_latch (.*);

endmodule

/* hdl/udp_first_byte_latch.sv */
// ==============================
// First byte LED latch
// Shows the first byte of each
// outgoing payload on the LEDs
// ==============================
`timescale 1ns/10ps

module udp_first_byte_latch (
    input  logic               clk_125mhz,
    input  logic               rst_125mhz,
    input  logic               tx_payload_valid,
    input  logic               tx_payload_ready,
    input  udp_hdr_pkg::byte_t tx_payload_data,
    input  logic               tx_payload_last,
    output udp_hdr_pkg::byte_t led
);
    logic frame_start;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            frame_start <= 1'b1;
            led         <= '0;
        end else if (tx_payload_valid && tx_payload_ready) begin
            if (frame_start) led <= tx_payload_data;
            // Next frame begins after a last byte
            frame_start <= tx_payload_last;
        end
    end

endmodule

/* hdl/udp_hdr_pkg.sv */
// ==============================
// UDP header types
// Field types of the UDP and IPv4
// headers and the payload byte
// ==============================

package udp_hdr_pkg;

    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;
    typedef logic [7:0]  ip_ttl_t;
    typedef logic [5:0]  ip_dscp_t;
    typedef logic [1:0]  ip_ecn_t;
    typedef logic [15:0] udp_csum_t;

    // One byte of UDP payload
    typedef logic [7:0]  byte_t;

endpackage

/* hdl/udp_payload_fifo.sv */
// ==============================
// UDP payload FIFO
// Synchronous byte FIFO carrying
// data, last and user
// ==============================
`timescale 1ns/10ps
`include "udp_echo_defines.svh"

module udp_payload_fifo #(
    parameter int DEPTH = `UDP_FIFO_DEPTH
) (
    input  logic               clk_125mhz,
    input  logic               rst_125mhz,
    input  logic               wr_valid,
    output logic               wr_ready,
    input  udp_hdr_pkg::byte_t wr_data,
    input  logic               wr_last,
    input  logic               wr_user,
    output logic               tx_payload_valid,
    input  logic               tx_payload_ready,
    output udp_hdr_pkg::byte_t tx_payload_data,
    output logic               tx_payload_last,
    output logic               tx_payload_user
);
    localparam int ADDR_W = $clog2(DEPTH);

    // Entry is {user, last, data}
    logic [9:0]      mem [DEPTH];
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;
    logic            full;
    logic            empty;
    logic            wr_fire;
    logic            rd_fire;

    // Extra pointer bit tells full from empty
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W])
        && (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    assign wr_ready = !full;
    assign wr_fire  = wr_valid && wr_ready;
    assign rd_fire  = tx_payload_valid && tx_payload_ready;

    always_ff @(posedge clk_125mhz) begin
        if (wr_fire) begin
            mem[wr_ptr[ADDR_W-1:0]] <= {wr_user, wr_last, wr_data};
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_fire) wr_ptr <= wr_ptr + 1'b1;
            if (rd_fire) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Read side shows the head entry as soon as it is written
    assign tx_payload_valid = !empty;
    assign {tx_payload_user, tx_payload_last, tx_payload_data} = mem[rd_ptr[ADDR_W-1:0]];

    // Occupancy below DEPTH whenever a write is taken
    a_no_write_when_full: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        wr_fire |-> ((ADDR_W+1)'(wr_ptr - rd_ptr) < DEPTH));

endmodule

/* hdl/udp_port_filter.sv */
// ==============================
// UDP echo port filter
// Accepts rx headers, decides echo
// or drop per frame and steers the
// payload to the FIFO or away
// ==============================
`timescale 1ns/10ps
`include "udp_echo_defines.svh"

module udp_port_filter (
    input  logic                   clk_125mhz,
    input  logic                   rst_125mhz,
    input  logic                   rx_hdr_valid,
    output logic                   rx_hdr_ready,
    input  udp_hdr_pkg::udp_port_t rx_dest_port,
    input  logic                   hdr_free,
    output logic                   hdr_load,
    input  udp_hdr_pkg::byte_t     rx_payload_data,
    input  logic                   rx_payload_valid,
    output logic                   rx_payload_ready,
    input  logic                   rx_payload_last,
    input  logic                   rx_payload_user,
    output logic                   wr_valid,
    input  logic                   wr_ready,
    output udp_hdr_pkg::byte_t     wr_data,
    output logic                   wr_last,
    output logic                   wr_user
);
    import udp_echo_pkg::*;

    filter_state_e state;
    logic          port_match;
    logic          hdr_fire;
    logic          last_fire;

    assign port_match = (rx_dest_port == `UDP_ECHO_PORT);

    // A matching header must wait for the reply header slot
    assign rx_hdr_ready = (state == st_idle) && (hdr_free || !port_match);
    assign hdr_fire     = rx_hdr_valid && rx_hdr_ready;
    assign hdr_load     = hdr_fire && port_match;

    // Echo passes bytes straight to the FIFO, drop swallows them
    assign wr_valid         = (state == st_echo) && rx_payload_valid;
    assign wr_data          = rx_payload_data;
    assign wr_last          = rx_payload_last;
    assign wr_user          = rx_payload_user;
    assign rx_payload_ready = ((state == st_echo) && wr_ready) || (state == st_drop);
    assign last_fire        = rx_payload_valid && rx_payload_ready && rx_payload_last;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (hdr_fire) begin
                        state <= port_match ? st_echo : st_drop;
                    end
                end
                st_echo, st_drop: begin
                    if (last_fire) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Header held by the source until the filter takes it
    a_hdr_held: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        rx_hdr_valid && !rx_hdr_ready |=> rx_hdr_valid && $stable(rx_dest_port));

    // Payload only follows an accepted header
    a_no_payload_in_idle: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        rx_payload_valid |-> (state != st_idle));

endmodule

/* hdl/udp_reply_header.sv */
// ==============================
// UDP reply header stage
// One-entry register building the
// echo reply header from rx fields
// ==============================
`timescale 1ns/10ps
`include "udp_echo_defines.svh"

module udp_reply_header (
    input  logic                   clk_125mhz,
    input  logic                   rst_125mhz,
    input  logic                   hdr_load,
    output logic                   hdr_free,
    input  udp_hdr_pkg::ip_addr_t  rx_ip_source_ip,
    input  udp_hdr_pkg::udp_port_t rx_source_port,
    input  udp_hdr_pkg::udp_port_t rx_dest_port,
    input  udp_hdr_pkg::udp_len_t  rx_length,
    output logic                   tx_hdr_valid,
    input  logic                   tx_hdr_ready,
    output udp_hdr_pkg::ip_addr_t  tx_ip_source_ip,
    output udp_hdr_pkg::ip_addr_t  tx_ip_dest_ip,
    output udp_hdr_pkg::ip_ttl_t   tx_ip_ttl,
    output udp_hdr_pkg::ip_dscp_t  tx_ip_dscp,
    output udp_hdr_pkg::ip_ecn_t   tx_ip_ecn,
    output udp_hdr_pkg::udp_port_t tx_source_port,
    output udp_hdr_pkg::udp_port_t tx_dest_port,
    output udp_hdr_pkg::udp_len_t  tx_length,
    output udp_hdr_pkg::udp_csum_t tx_checksum
);
    import udp_hdr_pkg::*;

    // Slot is free once the held header has been taken
    assign hdr_free = !tx_hdr_valid;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            tx_hdr_valid <= 1'b0;
        end else if (hdr_load) begin
            tx_hdr_valid <= 1'b1;
        end else if (tx_hdr_ready) begin
            tx_hdr_valid <= 1'b0;
        end
    end

    // Ports swapped, reply goes back to the sender
    always_ff @(posedge clk_125mhz) begin
        if (hdr_load) begin
            tx_source_port <= rx_dest_port;
            tx_dest_port   <= rx_source_port;
            tx_ip_dest_ip  <= rx_ip_source_ip;
            tx_length      <= rx_length;
        end
    end

    assign tx_ip_source_ip = `UDP_LOCAL_IP;
    assign tx_ip_ttl       = `UDP_ECHO_TTL;
    assign tx_ip_dscp      = ip_dscp_t'(0);
    assign tx_ip_ecn       = ip_ecn_t'(0);
    // No UDP checksum on replies
    assign tx_checksum     = udp_csum_t'(0);

    a_hdr_stable: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid
            && $stable({tx_source_port, tx_dest_port, tx_ip_dest_ip, tx_length}));

endmodule
